//--- hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;

    // Primary opcodes, bits 31:26 of the instruction
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // Funct codes for R-type, bits 5:0
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SLT,
        SLTU
    } alu_op_e;

    localparam reg_addr_t REG_V0 = 5'd2; // Result register seen by the outside

endpackage

`default_nettype wire

//--- hw/avalon_bus_pkg.sv
`default_nettype none

package avalon_bus_pkg;

    // Byte address, the CPU only issues word-aligned values
    typedef logic [31:0] bus_addr_t;

    typedef logic [31:0] bus_data_t;

    // One bit per byte lane of bus_data_t
    typedef logic [3:0]  bus_be_t;

endpackage

`default_nettype wire

//--- hw/mips_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module mips_regfile import mips_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin // $zero never changes
            regs[wr_addr] <= wr_data;
        end
    end

    // Both read ports are asynchronous
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    assign v0 = regs[REG_V0];

endmodule

`default_nettype wire

//--- hw/mips_alu.sv
`timescale 1ns/10ps
`default_nettype none

module mips_alu import mips_isa_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    input  shamt_t  shamt,
    output word_t   result
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ADD: begin
                result = a + b; // Wraps, no overflow trap
            end
            SUB: begin
                result = a - b;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            XOR: begin
                result = a ^ b;
            end
            SLL: begin
                result = b << shamt; // The shifted operand is rt
            end
            SLT: begin
                result = {31'b0, lt_signed};
            end
            SLTU: begin
                result = {31'b0, lt_unsigned};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mips_control.sv
`timescale 1ns/10ps
`default_nettype none

module mips_control import mips_isa_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  word_t   instr,
    input  logic    waitrequest,
    input  word_t   jr_target,
    output logic    state_fetch,
    output logic    ir_load,
    output logic    pc_load,
    output logic    pc_jump,
    output logic    mem_read,
    output logic    mem_write,
    output logic    rf_wr_en,
    output logic    rf_sel_rt_dest,
    output logic    rf_sel_mem,
    output alu_op_e alu_op,
    output logic    alu_sel_imm,
    output logic    imm_zero_ext,
    output logic    halted
);

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        HALT
    } state_e;

    state_e  state;
    state_e  state_next;
    logic    boot;       // High for the first cycle out of reset, holds off the fetch
    opcode_t opcode;
    funct_t  funct;
    logic    is_rtype;
    logic    is_jr;
    logic    is_lw;
    logic    is_sw;
    logic    writes_reg; // ALU result goes to the register file
    logic    jr_halt;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    assign is_rtype = opcode == OP_RTYPE;
    assign is_jr    = is_rtype && funct == FN_JR;
    assign is_lw    = opcode == OP_LW;
    assign is_sw    = opcode == OP_SW;
    assign jr_halt  = is_jr && jr_target == '0; // A return to address 0 ends the program

    // Decode of the ALU operation, loads and stores fall through to ADD for the address
    always_comb begin
        alu_op     = ADD;
        writes_reg = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                writes_reg = 1'b1;
                case (funct)
                    FN_SLL:  alu_op = SLL;
                    FN_ADDU: alu_op = ADD;
                    FN_SUBU: alu_op = SUB;
                    FN_AND:  alu_op = AND;
                    FN_OR:   alu_op = OR;
                    FN_XOR:  alu_op = XOR;
                    FN_SLT:  alu_op = SLT;
                    FN_SLTU: alu_op = SLTU;
                    default: writes_reg = 1'b0; // JR, and anything unknown acts as a no-op
                endcase
            end
            OP_ADDIU: begin
                alu_op     = ADD;
                writes_reg = 1'b1;
            end
            OP_ORI: begin
                alu_op     = OR;
                writes_reg = 1'b1;
            end
            default: begin
                alu_op = ADD;
            end
        endcase
    end

    assign rf_sel_rt_dest = !is_rtype; // I-type results land in rt
    assign alu_sel_imm    = !is_rtype;
    assign imm_zero_ext   = opcode == OP_ORI;
    assign rf_sel_mem     = is_lw;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            boot  <= 1'b1;
        end else begin
            state <= state_next;
            boot  <= 1'b0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH: begin
                if (!boot && !waitrequest) begin
                    state_next = DECODE;
                end
            end
            DECODE: begin
                state_next = EXECUTE;
            end
            EXECUTE: begin
                if (is_lw || is_sw) begin
                    state_next = MEMORY;
                end else if (jr_halt) begin
                    state_next = HALT;
                end else begin
                    state_next = FETCH;
                end
            end
            MEMORY: begin
                if (!waitrequest) begin // Sit here with the strobe up until the slave is ready
                    state_next = FETCH;
                end
            end
            HALT: begin
                state_next = HALT; // Only reset leaves this state
            end
            default: begin
                state_next = FETCH;
            end
        endcase
    end

    // Strobes come straight from the state, so they stay put across a stall
    assign state_fetch = state == FETCH;
    assign mem_read    = (state == FETCH && !boot) || (state == MEMORY && is_lw);
    assign mem_write   = state == MEMORY && is_sw;

    assign ir_load  = state == FETCH && !boot && !waitrequest;
    assign pc_jump  = state == EXECUTE && is_jr;
    assign pc_load  = ir_load || (pc_jump && !jr_halt);

    assign rf_wr_en = (state == EXECUTE && writes_reg)
                    || (state == MEMORY && is_lw && !waitrequest);

    assign halted = state == HALT;

endmodule

`default_nettype wire

//--- hw/mips_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module mips_cpu import mips_isa_pkg::*, avalon_bus_pkg::*; #(
    parameter bus_addr_t RESET_VECTOR = 32'h0000_0004
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      waitrequest,
    input  bus_data_t readdata,
    output bus_addr_t address,
    output logic      read,
    output logic      write,
    output bus_data_t writedata,
    output bus_be_t   byteenable,
    output logic      active,
    output word_t     register_v0
);

    bus_addr_t pc;
    word_t     ir;
    bus_data_t mdr; // Store data, held steady on the bus while any strobe is up

    logic      state_fetch;
    logic      ir_load;
    logic      pc_load;
    logic      pc_jump;
    logic      mem_read;
    logic      mem_write;
    logic      rf_wr_en;
    logic      rf_sel_rt_dest;
    logic      rf_sel_mem;
    alu_op_e   alu_op;
    logic      alu_sel_imm;
    logic      imm_zero_ext;
    logic      halted;

    word_t     rs_data;
    word_t     rt_data;
    word_t     imm_ext;
    word_t     alu_b;
    word_t     alu_result;
    reg_addr_t wr_addr;
    word_t     wr_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
        end else if (pc_load) begin
            pc <= pc_jump ? rs_data : pc + 32'd4; // There is no delay slot so JR goes straight to rs
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir <= readdata;
        end
        if (!mem_read && !mem_write) begin
            mdr <= rt_data;
        end
    end

    assign imm_ext = imm_zero_ext ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign alu_b   = alu_sel_imm ? imm_ext : rt_data;
    assign wr_addr = rf_sel_rt_dest ? ir[20:16] : ir[15:11];
    assign wr_data = rf_sel_mem ? readdata : alu_result;

    mips_control u_control (
        .clk            (clk),
        .rst            (rst),
        .instr          (ir),
        .waitrequest    (waitrequest),
        .jr_target      (rs_data),
        .state_fetch    (state_fetch),
        .ir_load        (ir_load),
        .pc_load        (pc_load),
        .pc_jump        (pc_jump),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .rf_wr_en       (rf_wr_en),
        .rf_sel_rt_dest (rf_sel_rt_dest),
        .rf_sel_mem     (rf_sel_mem),
        .alu_op         (alu_op),
        .alu_sel_imm    (alu_sel_imm),
        .imm_zero_ext   (imm_zero_ext),
        .halted         (halted)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (ir[25:21]),
        .rt_addr (ir[20:16]),
        .wr_en   (rf_wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .op     (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (ir[10:6]),
        .result (alu_result)
    );

    // Fetches use the PC while loads and stores use base plus offset from the ALU
    assign address    = state_fetch ? pc : alu_result;
    assign read       = mem_read;
    assign write      = mem_write;
    assign writedata  = mdr;
    assign byteenable = 4'b1111; // Word accesses only
    assign active     = !halted;

endmodule

`default_nettype wire

//--- tb/avalon_ram_model.sv
`timescale 1ns/10ps
`default_nettype none

module avalon_ram_model import avalon_bus_pkg::*; (
    input  logic      clk,
    input  bus_addr_t address,
    input  logic      read,
    input  logic      write,
    input  bus_data_t writedata,
    input  bus_be_t   byteenable,
    output bus_data_t readdata,
    output logic      waitrequest,
    input  logic      stall_en,
    input  logic      load_en,
    input  logic [7:0] load_addr,
    input  bus_data_t load_data
);

    localparam logic [31:0] LCG_SEED = 32'h4a73_53cb;

    bus_data_t   mem [256];
    logic [31:0] lcg_state = LCG_SEED;
    logic [1:0]  wait_cnt = 2'd0; // Stall cycles still owed to the current access

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Draws 0, 1 or 2 from the upper bits of the generator state
    function automatic logic [1:0] stall_from(input logic [31:0] s);
        return 2'((s >> 16) % 32'd3);
    endfunction

    assign readdata    = mem[address[9:2]];
    assign waitrequest = (read || write) && wait_cnt != 2'd0;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (read || write) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                // Transfer completes here, so the next access gets a fresh stall count
                if (write && byteenable == 4'b1111) begin
                    mem[address[9:2]] <= writedata;
                end
                lcg_state <= lcg_next(lcg_state);
                wait_cnt  <= stall_en ? stall_from(lcg_next(lcg_state)) : 2'd0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/mips_cpu_sva.sv
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_sva import avalon_bus_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      read,
    input logic      write,
    input bus_addr_t address,
    input bus_data_t writedata,
    input logic      waitrequest,
    input logic      active
);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else $error("read and write are high in the same cycle");

    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        (read || write) |-> address[1:0] == 2'b00)
        else $error("bus address is not word aligned");

    // A stalled master keeps its whole request unchanged
    a_hold_on_wait: assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitrequest |=> $stable(read) && $stable(write)
            && $stable(address) && $stable(writedata))
        else $error("bus request changed while waitrequest was high");

    a_reset_state: assert property (@(posedge clk) $fell(rst) |-> !read && !write && active)
        else $error("CPU not idle and active right after reset");

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst) !active |=> !active)
        else $error("active rose again without a reset");

endmodule

bind mips_cpu mips_cpu_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .read        (read),
    .write       (write),
    .address     (address),
    .writedata   (writedata),
    .waitrequest (waitrequest),
    .active      (active)
);

`default_nettype wire

//--- tb/mips_cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_tb import mips_isa_pkg::*, avalon_bus_pkg::*; ();

    localparam bus_addr_t RESET_VECTOR = 32'h0000_0004;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int MAX_INSTR    = 12;
    localparam int FILL_CYCLES  = 256;
    // Each instruction costs at most 4 cycles plus 2 stalls on each of two accesses
    localparam int TEST_CYCLES  = MAX_INSTR + 2 * RESET_CYCLES + MAX_INSTR * (4 + 2 * 2);
    localparam int TIMEOUT_CYCLES = (FILL_CYCLES + NUM_TESTS * TEST_CYCLES) * 4;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       waitrequest;
    bus_data_t  readdata;
    bus_addr_t  address;
    logic       read;
    logic       write;
    bus_data_t  writedata;
    bus_be_t    byteenable;
    logic       active;
    word_t      register_v0;
    logic       stall_en = 1'b0;
    logic       load_en = 1'b0;
    logic [7:0] load_addr = 8'd0;
    bus_data_t  load_data = '0;

    word_t prog [16];
    int    prog_len;
    int    errors = 0;
    int    passed = 0;
    int    cycle_count = 0;

    always #10 clk = ~clk;

    mips_cpu #(.RESET_VECTOR(RESET_VECTOR)) DUT (
        .clk(clk), .rst(rst), .waitrequest(waitrequest), .readdata(readdata),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .active(active), .register_v0(register_v0)
    );

    avalon_ram_model mem (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .waitrequest(waitrequest), .stall_en(stall_en), .load_en(load_en),
        .load_addr(load_addr), .load_data(load_data)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the CPU never dropped active", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic word_t enc_r(input int rs, input int rt, input int rd,
                                    input int sh, input funct_t fn);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t enc_i(input opcode_t op, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_instr(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_word(input logic [7:0] idx, input bus_data_t data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = idx;
        load_data = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            load_word(8'((RESET_VECTOR >> 2) + 32'(i)), prog[i]);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic wait_halt();
        while (active) @(negedge clk); // Timeout lives in the cycle counter
    endtask

    task automatic build_compare(input logic use_slt);
        prog_len = 0;
        add_instr(enc_i(OP_ADDIU, 0, 3, 16'hf00f));
        add_instr(enc_r(0, 3, 3, 16, FN_SLL));
        add_instr(enc_i(OP_ADDIU, 0, 4, 16'h0020));
        add_instr(enc_r(4, 3, 2, 0, use_slt ? FN_SLT : FN_SLTU));
        add_instr(enc_r(0, 0, 0, 0, FN_JR));
    endtask

    task automatic build_alu_chain();
        prog_len = 0;
        add_instr(enc_i(OP_ADDIU, 0, 5, 16'h1234));
        add_instr(enc_i(OP_ADDIU, 0, 6, 16'hff80));
        add_instr(enc_r(5, 6, 7, 0, FN_ADDU));
        add_instr(enc_r(5, 6, 8, 0, FN_SUBU));
        add_instr(enc_r(7, 8, 9, 0, FN_AND));
        add_instr(enc_r(7, 8, 10, 0, FN_OR));
        add_instr(enc_r(9, 10, 11, 0, FN_XOR));
        add_instr(enc_i(OP_ORI, 11, 12, 16'ha5a5));
        add_instr(enc_r(0, 12, 2, 3, FN_SLL));
        add_instr(enc_r(0, 0, 0, 0, FN_JR));
    endtask

    task automatic build_store_load();
        prog_len = 0;
        add_instr(enc_i(OP_ADDIU, 0, 5, 16'h0200)); // Data sits well above the code
        add_instr(enc_i(OP_ORI, 0, 6, 16'hbeef));
        add_instr(enc_r(0, 6, 6, 12, FN_SLL));
        add_instr(enc_i(OP_ORI, 6, 6, 16'h0123));
        add_instr(enc_i(OP_SW, 5, 6, 16'h0004));
        add_instr(enc_i(OP_LW, 5, 2, 16'h0004));
        add_instr(enc_r(0, 0, 0, 0, FN_JR));
    endtask

    function automatic word_t alu_chain_result();
        word_t a;
        word_t b;
        word_t e;
        word_t f;
        a = 32'h0000_1234;
        b = {16'hffff, 16'hff80}; // Sign-extended immediate
        e = (a + b) & (a - b);
        f = (a + b) | (a - b);
        return ((e ^ f) | 32'h0000_a5a5) << 3;
    endfunction

    task automatic check_v0(input int num, input string name, input word_t expected);
        logic ok;
        ok = 1'b1;
        assert (register_v0 == expected) else begin
            $display("[ERROR] %0t register_v0 expected %h actual %h",
                     $time, expected, register_v0);
            ok = 1'b0;
        end
        if (ok) begin
            passed++;
        end else begin
            errors++;
        end
        $display("test %0d %s: %s", num, name, ok ? "PASS" : "FAIL");
    endtask

    initial begin
        repeat (2) @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            load_word(8'(i), {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3});
        end

        build_compare(1'b0);
        load_program();
        apply_reset();
        wait_halt();
        check_v0(1, "sltu", 32'd1);

        build_compare(1'b1);
        load_program();
        apply_reset();
        wait_halt();
        check_v0(2, "slt", 32'd0);

        build_alu_chain();
        load_program();
        apply_reset();
        wait_halt();
        check_v0(3, "alu_chain", alu_chain_result());

        build_store_load();
        load_program();
        apply_reset();
        wait_halt();
        check_v0(4, "store_load", (32'h0000_beef << 12) | 32'h0000_0123);

        build_alu_chain();
        load_program();
        stall_en = 1'b1;
        apply_reset();
        wait_halt();
        check_v0(5, "alu_chain_stalled", alu_chain_result());
        stall_en = 1'b0;

        // Interrupt the run partway, the SVA checks the state right after reset
        build_compare(1'b0);
        load_program();
        apply_reset();
        repeat (7) @(negedge clk);
        apply_reset();
        wait_halt();
        check_v0(6, "reset_mid_run", 32'd1);

        $display("tests passed %0d, failed %0d, cycles %0d", passed, errors, cycle_count);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_sltu.f
hw/mips_isa_pkg.sv
hw/avalon_bus_pkg.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_control.sv
hw/mips_cpu.sv
tb/avalon_ram_model.sv
tb/mips_cpu_sva.sv
tb/mips_cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mips_cpu_tb \
    --Mdir obj_dir \
    -o mips_cpu_tb_sim \
    -f mips_sltu.f

output=$(./obj_dir/mips_cpu_tb_sim)
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
else
    exit 1
fi
